// ==== dv/tb_rvv_retire.sv ====
//////////////////////////////
// rvv retire testbench
// table of rob batches against a model
// of the retire rules, one batch at a time
//////////////////////////////

`timescale 1ns/10ps

`include "rvv_retire_settings.svh"

module tb_rvv_retire;

  import rvv_retire_pkg::*;

  // one stimulus row with slot 0 in the low bits of every field
  typedef struct packed {
    logic [`NUM_RT_UOP-1:0][`REGFILE_INDEX_WIDTH-1:0] idx;
    logic [`NUM_RT_UOP-1:0]                           typ;   // 1 xrf
    logic [`NUM_RT_UOP-1:0]                           sv;    // slot valid
    logic [`NUM_RT_UOP-1:0]                           wv;    // w_valid
    logic [`NUM_RT_UOP-1:0]                           trap;
    logic [`NUM_RT_UOP-1:0][2*`VLENB-1:0]             bt;    // byte types
    logic [`NUM_RT_UOP-1:0]                           xrdy;  // xrf ready while stalled
    logic [3:0]                                       stall;
  } row_t;

  logic                              clk;
  logic                              arst_n;
  logic [`NUM_RT_UOP-1:0]            rob_valid;
  rob2rt_t [`NUM_RT_UOP-1:0]         rob_data;
  logic [`NUM_RT_UOP-1:0]            rob_ready;
  logic [`NUM_RT_UOP-1:0]            xrf_valid;
  rt2xrf_t [`NUM_RT_UOP-1:0]         xrf_data;
  logic [`NUM_RT_UOP-1:0]            xrf_ready;
  logic [`NUM_RT_UOP-1:0]            vrf_valid;
  rt2vrf_t [`NUM_RT_UOP-1:0]         vrf_data;
  logic                              vcsr_valid;
  vcsr_t                             vcsr_data;
  logic                              vsat_valid;
  logic                              vsat_data;

  // model results for the batch in flight
  logic [`NUM_RT_UOP-1:0]            exp_vrf_valid;
  rt2vrf_t [`NUM_RT_UOP-1:0]         exp_vrf_data;
  logic [`NUM_RT_UOP-1:0]            exp_xrf_valid;
  rt2xrf_t [`NUM_RT_UOP-1:0]         exp_xrf_data;
  logic                              exp_vcsr_valid;
  vcsr_t                             exp_vcsr_data;
  logic                              exp_vsat_valid;
  logic                              exp_vsat_data;

  row_t        rows[$];
  logic [31:0] seed = 32'h26b0;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;  // 0 until the table is built

  rvv_retire_top i_rvv_retire_top (
    .clk                 (clk),
    .arst_n              (arst_n),
    .rob2rt_write_valid  (rob_valid),
    .rob2rt_write_data   (rob_data),
    .rob2rt_write_ready  (rob_ready),
    .rt2xrf_write_valid  (xrf_valid),
    .rt2xrf_write_data   (xrf_data),
    .rt2xrf_write_ready  (xrf_ready),
    .rt2vrf_write_valid  (vrf_valid),
    .rt2vrf_write_data   (vrf_data),
    .rt2vcsr_write_valid (vcsr_valid),
    .rt2vcsr_write_data  (vcsr_data),
    .rt2vsat_write_valid (vsat_valid),
    .rt2vsat_write_data  (vsat_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: batch did not drain within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // lcg
    return seed;
  endfunction

  task automatic compare(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input logic [4*`REGFILE_INDEX_WIDTH-1:0] idx,
                         input logic [3:0] typ, input logic [3:0] sv,
                         input logic [3:0] wv, input logic [3:0] trap,
                         input logic [8*`VLENB-1:0] bt, input logic [3:0] xrdy,
                         input int stall);
    row_t r;
    r.idx   = idx;
    r.typ   = typ;
    r.sv    = sv;
    r.wv    = wv;
    r.trap  = trap;
    r.bt    = bt;
    r.xrdy  = xrdy;
    r.stall = 4'(stall);
    rows.push_back(r);
  endtask

  // rob entries of one row with data and saturation from the lcg
  task automatic drive_batch(input row_t r);
    logic [31:0] rnd;
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      rob_data[k].w_valid = r.wv[k];
      rob_data[k].w_type  = r.typ[k];
      rob_data[k].w_index = r.idx[k];
      rob_data[k].w_data  = {next_rand(), next_rand()};
      for (int b = 0; b < `VLENB; b++) begin
        rob_data[k].vd_type[b] = byte_type_e'(r.bt[k][2*b +: 2]);
      end
      rob_data[k].trap_flag  = r.trap[k];
      rnd                    = next_rand();
      rob_data[k].vector_csr = vcsr_t'(rnd[21:0]);
      rob_data[k].vsaturate  = rnd[31:24];
    end
    rob_valid = r.sv;
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  task automatic model_batch();
    logic [`NUM_RT_UOP-1:0]             live;
    logic [`NUM_RT_UOP-1:0][`VLENB-1:0] full_strb;
    logic [`NUM_RT_UOP-1:0]             grp;
    logic [`VLENB-1:0]                  owned;
    logic                               seen_trap;
    logic                               run;
    logic                               flag;
    seen_trap = 1'b0;
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      live[k] = rob_valid[k] & rob_data[k].w_valid & ~seen_trap;  // trapper keeps its write
      if (rob_valid[k] && rob_data[k].trap_flag) seen_trap = 1'b1;
      for (int b = 0; b < `VLENB; b++) begin
        full_strb[k][b] = (rob_data[k].vd_type[b] == BODY_ACTIVE);
      end
    end
    grp[0] = 1'b1;
    for (int k = 1; k < `NUM_RT_UOP; k++) begin
      grp[k] = grp[k-1] & (rob_valid[k] == rob_valid[k-1]) &
               (rob_data[k].w_type == rob_data[k-1].w_type);
    end
    exp_vcsr_valid = 1'b0;
    exp_vcsr_data  = '0;
    exp_vsat_valid = 1'b0;
    exp_vsat_data  = 1'b0;
    run            = 1'b1;
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      owned = '0;
      for (int j = k + 1; j < `NUM_RT_UOP; j++) begin
        if (grp[j] && grp[k] && rob_data[j].w_index == rob_data[k].w_index) begin
          owned = owned | full_strb[j];  // newest writer wins
        end
      end
      exp_vrf_valid[k]          = live[k] & ~rob_data[k].w_type;
      exp_xrf_valid[k]          = live[k] & rob_data[k].w_type & run;
      run                       = exp_xrf_valid[k];
      exp_vrf_data[k].rt_index  = rob_data[k].w_index;
      exp_vrf_data[k].rt_data   = rob_data[k].w_data;
      exp_vrf_data[k].rt_strobe = full_strb[k] & ~owned;
      exp_xrf_data[k].rt_index  = rob_data[k].w_index;
      exp_xrf_data[k].rt_data   = rob_data[k].w_data[`XLEN-1:0];
      if (!exp_vcsr_valid && rob_valid[k] && rob_data[k].trap_flag) begin
        exp_vcsr_valid = 1'b1;  // oldest trap
        exp_vcsr_data  = rob_data[k].vector_csr;
      end
      flag           = |(rob_data[k].vsaturate & full_strb[k]);
      exp_vsat_valid = exp_vsat_valid | (live[k] & flag);
      exp_vsat_data  = exp_vsat_data | flag;
    end
  endtask

  // outputs of a held batch
  // leave says whether it drains this cycle
  task automatic check_held(input logic leave);
    compare("rob2rt_write_ready", 128'(rob_ready), 128'({`NUM_RT_UOP{leave}}));
    compare("rt2xrf_write_valid", 128'(xrf_valid), 128'(exp_xrf_valid));
    compare("rt2vrf_write_valid", 128'(vrf_valid),
            128'(exp_vrf_valid & {`NUM_RT_UOP{leave}}));
    compare("rt2vcsr_write_valid", 128'(vcsr_valid), 128'(exp_vcsr_valid & leave));
    compare("rt2vcsr_write_data", 128'(vcsr_data), 128'(exp_vcsr_data));
    compare("rt2vsat_write_valid", 128'(vsat_valid), 128'(exp_vsat_valid & leave));
    compare("rt2vsat_write_data", 128'(vsat_data), 128'(exp_vsat_data));
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      if (exp_xrf_valid[k]) begin
        compare($sformatf("rt2xrf_write_data[%0d]", k), 128'(xrf_data[k]),
                128'(exp_xrf_data[k]));
      end
      if (exp_vrf_valid[k]) begin
        compare($sformatf("rt2vrf_write_data[%0d]", k), 128'(vrf_data[k]),
                128'(exp_vrf_data[k]));
      end
    end
  endtask

  //////////////////////////////
  // table
  //////////////////////////////
  task automatic build_table();
    row_t        r;
    logic [31:0] rnd;
    // idx slot3..slot0, typ, sv, wv, trap, byte types, xrdy, stall
    add_row({5'd4, 5'd3, 5'd2, 5'd1}, 4'b0000, 4'b1111, 4'b1111, 4'b0000,
            {16'h9a6e, 16'h00ff, 16'h3333, 16'hffff}, 4'b1111, 0);  // plain vrf
    add_row({5'd5, 5'd5, 5'd5, 5'd5}, 4'b0000, 4'b1111, 4'b1111, 4'b0000,
            {16'h00ff, 16'hffff, 16'hcccc, 16'hffff}, 4'b1111, 0);  // waw
    add_row({5'd7, 5'd7, 5'd7, 5'd7}, 4'b0100, 4'b1111, 4'b1111, 4'b0000,
            {16'hffff, 16'hffff, 16'hff00, 16'hffff}, 4'b1111, 0);  // group break
    add_row({5'd9, 5'd9, 5'd8, 5'd8}, 4'b0000, 4'b1111, 4'b1111, 4'b0110,
            {16'hffff, 16'hffff, 16'hffff, 16'h3333}, 4'b1111, 0);  // trap
    add_row({5'd1, 5'd1, 5'd1, 5'd1}, 4'b0000, 4'b1111, 4'b1111, 4'b0001,
            {16'hffff, 16'hffff, 16'hffff, 16'h5555}, 4'b1111, 0);  // sat only behind trap
    add_row({5'd3, 5'd2, 5'd1, 5'd0}, 4'b1011, 4'b1111, 4'b1111, 4'b0000,
            {16'hffff, 16'h0fff, 16'hffff, 16'hffff}, 4'b1111, 0);  // xrf prefix
    add_row({5'd3, 5'd2, 5'd1, 5'd0}, 4'b1111, 4'b1110, 4'b1111, 4'b0000,
            {16'hffff, 16'hffff, 16'hffff, 16'hffff}, 4'b1111, 0);  // slot 0 idle
    add_row({5'd6, 5'd6, 5'd2, 5'd1}, 4'b0011, 4'b1111, 4'b1111, 4'b1000,
            {16'hffff, 16'hcccc, 16'hffff, 16'hffff}, 4'b0000, 5);  // stall
    add_row({5'd1, 5'd3, 5'd2, 5'd1}, 4'b0111, 4'b1111, 4'b1111, 4'b0000,
            {16'hffff, 16'hffff, 16'hffff, 16'hffff}, 4'b0011, 3);  // partial ready
    add_row({5'd2, 5'd2, 5'd2, 5'd2}, 4'b0000, 4'b0111, 4'b1101, 4'b0000,
            {16'h5a5a, 16'hffff, 16'hf0f0, 16'hffff}, 4'b1111, 0);  // no w_valid
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < `NUM_RT_UOP; k++) begin
        rnd         = next_rand();
        r.idx[k]    = {3'b000, rnd[1:0]};  // few indices so waw hits are common
        r.bt[k]     = rnd[31:16];
      end
      rnd    = next_rand();
      r.typ  = rnd[3:0];
      r.sv   = (rnd[7:4] == 4'b0000) ? 4'b0001 : rnd[7:4];
      r.wv   = rnd[11:8] | rnd[15:12];
      r.trap = rnd[19:16] & rnd[23:20];
      r.xrdy = rnd[27:24];
      r.stall = {2'b00, rnd[29:28]};
      rows.push_back(r);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    int   err_before;
    int   cyc;
    logic left;
    logic leave;
    arst_n    = 1'b0;
    rob_valid = '0;
    rob_data  = '0;
    xrf_ready = '0;
    build_table();
    cycle_limit = 16 + 4;
    foreach (rows[i]) cycle_limit += int'(rows[i].stall) + 4;

    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    #1;
    compare("rob2rt_write_ready", 128'(rob_ready), 128'({`NUM_RT_UOP{1'b1}}));
    compare("rt2xrf_write_valid", 128'(xrf_valid), 128'(0));
    compare("rt2vrf_write_valid", 128'(vrf_valid), 128'(0));
    compare("rt2vcsr_write_valid", 128'(vcsr_valid), 128'(0));
    compare("rt2vsat_write_valid", 128'(vsat_valid), 128'(0));

    for (int i = 0; i < rows.size(); i++) begin
      err_before = errors;
      @(negedge clk);
      drive_batch(rows[i]);
      xrf_ready = '1;
      #1;
      compare("rob2rt_write_ready", 128'(rob_ready), 128'({`NUM_RT_UOP{1'b1}}));
      compare("rt2vrf_write_valid", 128'(vrf_valid), 128'(0));  // register empty
      model_batch();
      cyc = 0;
      do begin
        @(negedge clk);
        xrf_ready = (cyc < int'(rows[i].stall)) ? rows[i].xrdy : '1;
        leave     = ((exp_xrf_valid & ~xrf_ready) == '0);
        if (leave) begin
          rob_valid = '0;
        end else begin
          drive_batch(rows[i]);  // new batch the stalled dut must not take
        end
        #1;
        check_held(leave);
        left = rob_ready[0];
        cyc++;
      end while (!left);
      $display("test %0d: %0d cycles held, %0d errors", i, cyc, errors - err_before);
    end

    $display("%0d tests, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== include/rvv_retire_settings.svh ====
//////////////////////////////
// rvv retire settings
// sizes shared by the retire stage
//////////////////////////////

`ifndef RVV_RETIRE_SETTINGS_SVH
`define RVV_RETIRE_SETTINGS_SVH

// retire slots per batch, slot 0 oldest
`define NUM_RT_UOP 4

// vector register geometry
`define VLEN  64
`define VLENB 8     // bytes per vector register

// scalar side
`define XLEN 32

`define REGFILE_INDEX_WIDTH 5   // vd / rd index
`define VL_WIDTH            8   // vl and vstart fields

`endif

// ==== list.f ====
+incdir+include
rtl/rvv_retire_pkg.sv
rtl/rvv_retire_decode.sv
rtl/rvv_retire_waw.sv
rtl/rvv_retire_route.sv
rtl/rvv_retire_wb_reg.sv
rtl/rvv_retire_top.sv
dv/tb_rvv_retire.sv

// ==== rtl/rvv_retire_decode.sv ====
//////////////////////////////
// rvv retire decode
// per slot byte strobe, saturation flag
// and squash of slots behind a trap
//////////////////////////////

`timescale 1ns/10ps

`include "rvv_retire_settings.svh"

module rvv_retire_decode (
  input  logic [`NUM_RT_UOP-1:0]                      rob_valid,
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0]   rob_data,
  output rvv_retire_pkg::rt_entry_t [`NUM_RT_UOP-1:0] entry
);

  import rvv_retire_pkg::*;

  logic [`NUM_RT_UOP-1:0]            trap_before; // an older valid slot traps
  logic [`NUM_RT_UOP-1:0][`VLENB-1:0] active;      // body active bytes

  //////////////////////////////
  // trap squash
  //////////////////////////////
  always_comb begin
    trap_before[0] = 1'b0; // nothing older than slot 0
    for (int k = 1; k < `NUM_RT_UOP; k++) begin
      trap_before[k] = trap_before[k-1] | (rob_valid[k-1] & rob_data[k-1].trap_flag);
    end
  end

  // byte classes to write enables
  always_comb begin
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      for (int b = 0; b < `VLENB; b++) begin
        active[k][b] = (rob_data[k].vd_type[b] == BODY_ACTIVE);
      end
    end
  end

  //////////////////////////////
  // decoded slots
  //////////////////////////////
  always_comb begin
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      // the trapping slot itself still retires its write
      entry[k].live   = rob_valid[k] & rob_data[k].w_valid & ~trap_before[k];
      entry[k].is_xrf = rob_data[k].w_type;
      entry[k].index  = rob_data[k].w_index;
      entry[k].data   = rob_data[k].w_data;
      entry[k].strobe = active[k];
      // saturation only counts on bytes that really get written
      entry[k].vxsat  = |(rob_data[k].vsaturate & active[k]);
    end
  end

endmodule

// ==== rtl/rvv_retire_pkg.sv ====
//////////////////////////////
// rvv retire types
// byte classes, rob entry, decoded entry,
// vrf/xrf write records and vector csr state
//////////////////////////////

`include "rvv_retire_settings.svh"

package rvv_retire_pkg;

  // class of one destination byte, only body active bytes get written
  typedef enum logic [1:0] {
    PROLOGUE      = 2'b00,
    TAIL          = 2'b01,
    BODY_INACTIVE = 2'b10,
    BODY_ACTIVE   = 2'b11
  } byte_type_e;

  // vector csr state reported on a trap
  typedef struct packed {
    logic [`VL_WIDTH-1:0] vstart;
    logic [`VL_WIDTH-1:0] vl;
    logic [2:0]           vsew;
    logic [2:0]           vlmul;
  } vcsr_t;

  //////////////////////////////
  // rob side
  typedef struct packed {
    logic                            w_valid;
    logic                            w_type;      // 0 vrf, 1 xrf
    logic [`REGFILE_INDEX_WIDTH-1:0] w_index;
    logic [`VLEN-1:0]                w_data;
    byte_type_e [`VLENB-1:0]         vd_type;
    logic                            trap_flag;
    vcsr_t                           vector_csr;
    logic [`VLENB-1:0]               vsaturate;   // per byte saturation
  } rob2rt_t;

  // one retire slot after decode
  typedef struct packed {
    logic                            live;        // valid after trap squash
    logic                            is_xrf;
    logic [`REGFILE_INDEX_WIDTH-1:0] index;
    logic [`VLEN-1:0]                data;
    logic [`VLENB-1:0]               strobe;      // before waw masking
    logic                            vxsat;
  } rt_entry_t;

  //////////////////////////////
  // write-back records
  typedef struct packed {
    logic [`REGFILE_INDEX_WIDTH-1:0] rt_index;
    logic [`VLEN-1:0]                rt_data;
    logic [`VLENB-1:0]               rt_strobe;
  } rt2vrf_t;

  typedef struct packed {
    logic [`REGFILE_INDEX_WIDTH-1:0] rt_index;
    logic [`XLEN-1:0]                rt_data;
  } rt2xrf_t;

endpackage

// ==== rtl/rvv_retire_route.sv ====
//////////////////////////////
// rvv retire route
// vrf/xrf write records and valids,
// trap csr select and vxsat merge
//////////////////////////////

`timescale 1ns/10ps

`include "rvv_retire_settings.svh"

module rvv_retire_route (
  input  logic [`NUM_RT_UOP-1:0]                      rob_valid,
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0]   rob_data,
  input  rvv_retire_pkg::rt_entry_t [`NUM_RT_UOP-1:0] entry,
  input  logic [`NUM_RT_UOP-1:0][`VLENB-1:0]          strobe,
  output logic [`NUM_RT_UOP-1:0]                      vrf_valid,
  output rvv_retire_pkg::rt2vrf_t [`NUM_RT_UOP-1:0]   vrf_data,
  output logic [`NUM_RT_UOP-1:0]                      xrf_valid,
  output rvv_retire_pkg::rt2xrf_t [`NUM_RT_UOP-1:0]   xrf_data,
  output logic                                        vcsr_valid,
  output rvv_retire_pkg::vcsr_t                       vcsr_data,
  output logic                                        vsat_valid,
  output logic                                        vsat_data
);

  import rvv_retire_pkg::*;

  //////////////////////////////
  // vrf / xrf ports
  //////////////////////////////
  always_comb begin
    logic run; // all older slots went to the xrf
    run = 1'b1;
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      vrf_valid[k] = entry[k].live & ~entry[k].is_xrf;
      // xrf ports fill as a contiguous run from slot 0
      xrf_valid[k] = entry[k].live & entry[k].is_xrf & run;
      run          = xrf_valid[k];

      vrf_data[k].rt_index  = entry[k].index;
      vrf_data[k].rt_data   = entry[k].data;
      vrf_data[k].rt_strobe = strobe[k];  // after waw

      xrf_data[k].rt_index  = entry[k].index;
      xrf_data[k].rt_data   = entry[k].data[`XLEN-1:0];
    end
  end

  //////////////////////////////
  // trap csr
  //////////////////////////////
  // walk youngest to oldest so the oldest trap is the one left over
  always_comb begin
    vcsr_valid = 1'b0;
    vcsr_data  = '0;
    for (int k = `NUM_RT_UOP - 1; k >= 0; k--) begin
      if (rob_valid[k] && rob_data[k].trap_flag) begin
        vcsr_valid = 1'b1;
        vcsr_data  = rob_data[k].vector_csr;
      end
    end
  end

  // vxsat
  always_comb begin
    vsat_valid = 1'b0;
    vsat_data  = 1'b0;
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      vsat_valid = vsat_valid | (entry[k].live & entry[k].vxsat);
      vsat_data  = vsat_data | entry[k].vxsat;  // not gated by live
    end
  end

endmodule

// ==== rtl/rvv_retire_top.sv ====
//////////////////////////////
// rvv retire top
// retire stage of the vector back end,
// rob batch in, vrf/xrf/csr writes out
// one cycle later
//////////////////////////////

`timescale 1ns/10ps

`include "rvv_retire_settings.svh"

module rvv_retire_top (
  input  logic                                      clk,
  input  logic                                      arst_n,
  // rob
  input  logic [`NUM_RT_UOP-1:0]                    rob2rt_write_valid,
  input  rvv_retire_pkg::rob2rt_t [`NUM_RT_UOP-1:0] rob2rt_write_data,
  output logic [`NUM_RT_UOP-1:0]                    rob2rt_write_ready,
  // xrf
  output logic [`NUM_RT_UOP-1:0]                    rt2xrf_write_valid,
  output rvv_retire_pkg::rt2xrf_t [`NUM_RT_UOP-1:0] rt2xrf_write_data,
  input  logic [`NUM_RT_UOP-1:0]                    rt2xrf_write_ready,
  // vrf, no ready
  output logic [`NUM_RT_UOP-1:0]                    rt2vrf_write_valid,
  output rvv_retire_pkg::rt2vrf_t [`NUM_RT_UOP-1:0] rt2vrf_write_data,
  // vector csr and vxsat
  output logic                                      rt2vcsr_write_valid,
  output rvv_retire_pkg::vcsr_t                     rt2vcsr_write_data,
  output logic                                      rt2vsat_write_valid,
  output logic                                      rt2vsat_write_data
);

  import rvv_retire_pkg::*;

  rt_entry_t [`NUM_RT_UOP-1:0]          entry;
  logic [`NUM_RT_UOP-1:0][`VLENB-1:0]   strobe;
  logic [`NUM_RT_UOP-1:0]               vrf_valid;
  rt2vrf_t [`NUM_RT_UOP-1:0]            vrf_data;
  logic [`NUM_RT_UOP-1:0]               xrf_valid;
  rt2xrf_t [`NUM_RT_UOP-1:0]            xrf_data;
  logic                                 vcsr_valid;
  vcsr_t                                vcsr_data;
  logic                                 vsat_valid;
  logic                                 vsat_data;
  logic                                 load;
  logic                                 accept;

  // whole rob stalls together
  assign load               = (|rob2rt_write_valid) & accept;
  assign rob2rt_write_ready = {`NUM_RT_UOP{accept}};

  //////////////////////////////
  // combinational retire path
  //////////////////////////////
  rvv_retire_decode i_decode (
    .rob_valid (rob2rt_write_valid),
    .rob_data  (rob2rt_write_data),
    .entry     (entry)
  );

  rvv_retire_waw i_waw (
    .rob_valid (rob2rt_write_valid),
    .entry     (entry),
    .strobe    (strobe)
  );

  rvv_retire_route i_route (
    .rob_valid  (rob2rt_write_valid),
    .rob_data   (rob2rt_write_data),
    .entry      (entry),
    .strobe     (strobe),
    .vrf_valid  (vrf_valid),
    .vrf_data   (vrf_data),
    .xrf_valid  (xrf_valid),
    .xrf_data   (xrf_data),
    .vcsr_valid (vcsr_valid),
    .vcsr_data  (vcsr_data),
    .vsat_valid (vsat_valid),
    .vsat_data  (vsat_data)
  );

  // registered write-back
  rvv_retire_wb_reg i_wb_reg (
    .clk                 (clk),
    .arst_n              (arst_n),
    .load                (load),
    .vrf_valid           (vrf_valid),
    .vrf_data            (vrf_data),
    .xrf_valid           (xrf_valid),
    .xrf_data            (xrf_data),
    .vcsr_valid          (vcsr_valid),
    .vcsr_data           (vcsr_data),
    .vsat_valid          (vsat_valid),
    .vsat_data           (vsat_data),
    .rt2xrf_write_ready  (rt2xrf_write_ready),
    .rt2vrf_write_valid  (rt2vrf_write_valid),
    .rt2vrf_write_data   (rt2vrf_write_data),
    .rt2xrf_write_valid  (rt2xrf_write_valid),
    .rt2xrf_write_data   (rt2xrf_write_data),
    .rt2vcsr_write_valid (rt2vcsr_write_valid),
    .rt2vcsr_write_data  (rt2vcsr_write_data),
    .rt2vsat_write_valid (rt2vsat_write_valid),
    .rt2vsat_write_data  (rt2vsat_write_data),
    .accept              (accept)
  );

endmodule

// ==== rtl/rvv_retire_waw.sv ====
//////////////////////////////
// rvv retire waw
// newest-wins byte ownership between
// same-register writes of one batch
//////////////////////////////

`timescale 1ns/10ps

`include "rvv_retire_settings.svh"

module rvv_retire_waw (
  input  logic [`NUM_RT_UOP-1:0]                      rob_valid,
  input  rvv_retire_pkg::rt_entry_t [`NUM_RT_UOP-1:0] entry,
  output logic [`NUM_RT_UOP-1:0][`VLENB-1:0]          strobe
);

  import rvv_retire_pkg::*;

  logic [`NUM_RT_UOP-1:0]             in_grp; // slot is inside the prefix group
  logic [`NUM_RT_UOP-1:0][`VLENB-1:0] kill;   // bytes owned by a younger slot

  //////////////////////////////
  // same destination prefix
  //////////////////////////////
  // group grows from slot 0 while slot valid and w_type both match,
  // it stops at the first slot that differs
  always_comb begin
    in_grp[0] = 1'b1;
    for (int k = 1; k < `NUM_RT_UOP; k++) begin
      in_grp[k] = in_grp[k-1] &&
                  ({rob_valid[k], entry[k].is_xrf} == {rob_valid[k-1], entry[k-1].is_xrf});
    end
  end

  //////////////////////////////
  // byte masking
  //////////////////////////////
  always_comb begin
    for (int k = 0; k < `NUM_RT_UOP; k++) begin
      kill[k] = '0;
      for (int j = k + 1; j < `NUM_RT_UOP; j++) begin
        // younger slot in the group implies slot k is in it too
        if (in_grp[j] && (entry[j].index == entry[k].index)) begin
          kill[k] = kill[k] | entry[j].strobe; // unmasked younger strobe
        end
      end
      strobe[k] = entry[k].strobe & ~kill[k];
    end
  end

  // youngest slot never loses a byte
  // slots outside the group see kill == 0 and pass unchanged

endmodule

// ==== rtl/rvv_retire_wb_reg.sv ====
//////////////////////////////
// rvv retire write-back register
// holds one retired batch, waits for
// xrf ready, pulses vrf/csr/vsat once
//////////////////////////////

`timescale 1ns/10ps

`include "rvv_retire_settings.svh"

module rvv_retire_wb_reg (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      load,
  input  logic [`NUM_RT_UOP-1:0]                    vrf_valid,
  input  rvv_retire_pkg::rt2vrf_t [`NUM_RT_UOP-1:0] vrf_data,
  input  logic [`NUM_RT_UOP-1:0]                    xrf_valid,
  input  rvv_retire_pkg::rt2xrf_t [`NUM_RT_UOP-1:0] xrf_data,
  input  logic                                      vcsr_valid,
  input  rvv_retire_pkg::vcsr_t                     vcsr_data,
  input  logic                                      vsat_valid,
  input  logic                                      vsat_data,
  input  logic [`NUM_RT_UOP-1:0]                    rt2xrf_write_ready,
  output logic [`NUM_RT_UOP-1:0]                    rt2vrf_write_valid,
  output rvv_retire_pkg::rt2vrf_t [`NUM_RT_UOP-1:0] rt2vrf_write_data,
  output logic [`NUM_RT_UOP-1:0]                    rt2xrf_write_valid,
  output rvv_retire_pkg::rt2xrf_t [`NUM_RT_UOP-1:0] rt2xrf_write_data,
  output logic                                      rt2vcsr_write_valid,
  output rvv_retire_pkg::vcsr_t                     rt2vcsr_write_data,
  output logic                                      rt2vsat_write_valid,
  output logic                                      rt2vsat_write_data,
  output logic                                      accept
);

  import rvv_retire_pkg::*;

  logic                   full_q;
  logic [`NUM_RT_UOP-1:0] vrf_valid_q;
  logic                   vcsr_valid_q;
  logic                   vsat_valid_q;
  logic                   leave;        // held batch drains this cycle

  // every asserted xrf port must see ready, no partial drain
  assign leave  = full_q && ((rt2xrf_write_valid & ~rt2xrf_write_ready) == '0);
  assign accept = ~full_q | leave;

  //////////////////////////////
  // control state
  //////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q             <= 1'b0;
      vrf_valid_q        <= '0;
      rt2xrf_write_valid <= '0;
      vcsr_valid_q       <= 1'b0;
      vsat_valid_q       <= 1'b0;
    end else if (accept) begin
      full_q             <= load;
      vrf_valid_q        <= load ? vrf_valid : '0;
      rt2xrf_write_valid <= load ? xrf_valid : '0;  // stays up while held
      vcsr_valid_q       <= load & vcsr_valid;
      vsat_valid_q       <= load & vsat_valid;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (accept && load) begin
      rt2vrf_write_data  <= vrf_data;
      rt2xrf_write_data  <= xrf_data;
      rt2vcsr_write_data <= vcsr_data;
      rt2vsat_write_data <= vsat_data;
    end
  end

  // single pulse in the leaving cycle
  assign rt2vrf_write_valid  = vrf_valid_q & {`NUM_RT_UOP{leave}};
  assign rt2vcsr_write_valid = vcsr_valid_q & leave;
  assign rt2vsat_write_valid = vsat_valid_q & leave;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the retire stage testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -j 0 \
  -f list.f --top-module tb_rvv_retire -o sim_rvv_retire

./obj_dir/sim_rvv_retire | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "run passed"
else
  echo "run failed, see sim.log"
  exit 1
fi
